//--- burst_map.f
common/burst_cfg_pkg.sv
common/burst_types_pkg.sv
common/sub_req_if.sv
design/handoff_reg.sv
burst_map/burst_gearbox.sv
design/rsp_merge.sv
design/burst_map_top.sv
verification/burst_map_chk.sv
verification/burst_map_tb.sv

//--- burst_map/burst_gearbox.sv
// Splits a requester burst of up to 64 beats into port bursts of up to 8 beats.
// With NATURAL_ALIGNMENT each sub-burst start is a multiple of its own length.
// One requester burst is split at a time.
`timescale 1ns/1ps
`default_nettype none

module burst_gearbox import burst_cfg_pkg::*; import burst_types_pkg::*; #(
    parameter bit NATURAL_ALIGNMENT = 1'b1
) (
    input  logic   clk,
    input  logic   reset_n,
    input  logic   m_valid,
    input  m_req_t m_req,
    output logic   m_ready,
    sub_req_if.src sub
);

    // Remaining beats need one more bit than the length field
    localparam int REM_W     = M_LEN_W + 1;
    // Beats of one sub-burst, 1 to MAX_BEATS
    localparam int BEAT_W    = S_LEN_W + 1;
    localparam int MAX_BEATS = 1 << S_LEN_W;

    logic              busy;
    logic [ADDR_W-1:0] cur_addr;
    logic [REM_W-1:0]  rem_beats;
    logic [ID_W-1:0]   cur_id;
    logic [BEAT_W-1:0] sub_beats;
    logic              sub_xfer;
    logic              m_xfer;

    // Length of the next sub-burst for a given start address and remaining count
    function automatic logic [BEAT_W-1:0] pick_beats(
        input logic [ADDR_W-1:0] addr,
        input logic [REM_W-1:0]  rem
    );
        logic [REM_W-1:0]  cap;
        logic [BEAT_W-1:0] beats;
        cap   = (rem > REM_W'(MAX_BEATS)) ? REM_W'(MAX_BEATS) : rem;
        beats = cap[BEAT_W-1:0];
        if (NATURAL_ALIGNMENT)
        begin
            // Both conditions hold for every smaller power once they hold,
            // so the last match in the ascending scan is the largest one
            beats = BEAT_W'(1);
            for (int k = 0; k <= S_LEN_W; k++)
            begin
                if ((cap >= REM_W'(1 << k)) &&
                    ((addr & ADDR_W'((1 << k) - 1)) == '0))
                    beats = BEAT_W'(1 << k);
            end
        end
        return beats;
    endfunction

    assign sub_beats = pick_beats(cur_addr, rem_beats);

    assign sub.valid = busy;
    assign sub.addr  = cur_addr;
    assign sub.len   = S_LEN_W'(sub_beats - BEAT_W'(1));
    assign sub.id    = cur_id;
    // The final sub-burst covers exactly what is left
    assign sub.last  = (rem_beats == REM_W'(sub_beats));

    assign sub_xfer = sub.valid && sub.ready;

    // Take the next burst when idle or while the final sub-burst leaves
    assign m_ready = !busy || (sub_xfer && sub.last);
    assign m_xfer  = m_valid && m_ready;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            busy <= 1'b0;
        else if (m_ready)
            busy <= m_valid;
    end

    // Split state is loaded on accept and advanced on every sub-burst transfer
    always_ff @(posedge clk)
    begin
        if (m_xfer)
        begin
            cur_addr  <= m_req.addr;
            rem_beats <= REM_W'(m_req.len) + REM_W'(1);
            cur_id    <= m_req.id;
        end
        else if (sub_xfer)
        begin
            cur_addr  <= cur_addr + ADDR_W'(sub_beats);
            rem_beats <= rem_beats - REM_W'(sub_beats);
        end
    end

endmodule

`default_nettype wire

//--- common/burst_cfg_pkg.sv
// Width and depth constants for the burst splitting adapter.
// Length fields of both sides hold beats minus one.
`default_nettype none

package burst_cfg_pkg;

    // Beat address width, in units of beats rather than bytes
    localparam int ADDR_W = 16;

    // Requester length field, up to 64 beats
    localparam int M_LEN_W = 6;

    // Port length field, up to 8 beats per burst
    localparam int S_LEN_W = 3;

    // Requester id width
    localparam int ID_W = 4;

    // Default number of sub-bursts that may wait for a port response
    localparam int RSP_DEPTH_DEF = 8;

endpackage

`default_nettype wire

//--- common/burst_types_pkg.sv
// Payload structs for the requester side of the adapter.
// Field widths follow burst_cfg_pkg.
`default_nettype none

package burst_types_pkg;

    import burst_cfg_pkg::*;

    // One requester burst as seen on the request channel
    typedef struct packed {
        logic [ADDR_W-1:0]  addr;
        // Beats minus one
        logic [M_LEN_W-1:0] len;
        logic [ID_W-1:0]    id;
    } m_req_t;

    // One merged response returned to the requester
    typedef struct packed {
        logic [ID_W-1:0] id;
        // OR of the error bits of all sub-burst responses
        logic            err;
    } m_rsp_t;

endpackage

`default_nettype wire

//--- common/sub_req_if.sv
// Sub-burst request channel between the gearbox and the response merger.
// A transfer happens when valid and ready are both high.
`timescale 1ns/1ps
`default_nettype none

interface sub_req_if import burst_cfg_pkg::*; ();

    logic               valid;
    logic               ready;
    // Beat address of the first beat of this sub-burst
    logic [ADDR_W-1:0]  addr;
    // Port length field, beats minus one
    logic [S_LEN_W-1:0] len;
    // Id of the requester burst this sub-burst belongs to
    logic [ID_W-1:0]    id;
    // Set on the sub-burst that closes its requester burst
    logic               last;

    // The gearbox drives the payload and holds it stable while stalled
    modport src (
        output valid,
        output addr,
        output len,
        output id,
        output last,
        input  ready
    );

    // The merger forwards the payload to the port and records id and last
    modport dst (
        input  valid,
        input  addr,
        input  len,
        input  id,
        input  last,
        output ready
    );

endinterface

`default_nettype wire

//--- design/burst_map_top.sv
// Burst splitting adapter between a requester and a memory port.
// Requester bursts up to 64 beats, port bursts up to 8 beats.
// One merged response returns per requester burst, in request order.
`timescale 1ns/1ps
`default_nettype none

module burst_map_top import burst_cfg_pkg::*; import burst_types_pkg::*; #(
    parameter bit NATURAL_ALIGNMENT = 1'b1,
    parameter int RSP_DEPTH         = RSP_DEPTH_DEF
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               req_valid,
    output logic               req_ready,
    input  logic [ADDR_W-1:0]  req_addr,
    input  logic [M_LEN_W-1:0] req_len,
    input  logic [ID_W-1:0]    req_id,
    output logic               sub_valid,
    input  logic               sub_ready,
    output logic [ADDR_W-1:0]  sub_addr,
    output logic [S_LEN_W-1:0] sub_len,
    input  logic               prsp_valid,
    output logic               prsp_ready,
    input  logic               prsp_err,
    output logic               rsp_valid,
    input  logic               rsp_ready,
    output logic [ID_W-1:0]    rsp_id,
    output logic               rsp_err
);

    m_req_t req_in;
    m_req_t gb_req;
    logic   gb_valid;
    logic   gb_ready;
    m_rsp_t mrg_rsp;
    logic   mrg_valid;
    logic   mrg_ready;
    m_rsp_t rsp_out;

    sub_req_if sub_bus ();

    assign req_in.addr = req_addr;
    assign req_in.len  = req_len;
    assign req_in.id   = req_id;

    // Registered request stage ahead of the gearbox
    handoff_reg #(
        .payload_t(m_req_t)
    ) req_stage (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (req_valid),
        .in_data   (req_in),
        .in_ready  (req_ready),
        .out_valid (gb_valid),
        .out_data  (gb_req),
        .out_ready (gb_ready)
    );

    burst_gearbox #(
        .NATURAL_ALIGNMENT(NATURAL_ALIGNMENT)
    ) burst_gearbox_i (
        .clk     (clk),
        .reset_n (reset_n),
        .m_valid (gb_valid),
        .m_req   (gb_req),
        .m_ready (gb_ready),
        .sub     (sub_bus.src)
    );

    rsp_merge #(
        .RSP_DEPTH(RSP_DEPTH)
    ) rsp_merge_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .sub        (sub_bus.dst),
        .sub_valid  (sub_valid),
        .sub_ready  (sub_ready),
        .sub_addr   (sub_addr),
        .sub_len    (sub_len),
        .prsp_valid (prsp_valid),
        .prsp_ready (prsp_ready),
        .prsp_err   (prsp_err),
        .out_valid  (mrg_valid),
        .out_rsp    (mrg_rsp),
        .out_ready  (mrg_ready)
    );

    // Its in_ready is what throttles the port responses
    handoff_reg #(
        .payload_t(m_rsp_t)
    ) rsp_stage (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (mrg_valid),
        .in_data   (mrg_rsp),
        .in_ready  (mrg_ready),
        .out_valid (rsp_valid),
        .out_data  (rsp_out),
        .out_ready (rsp_ready)
    );

    assign rsp_id  = rsp_out.id;
    assign rsp_err = rsp_out.err;

endmodule

`default_nettype wire

//--- design/handoff_reg.sv
// Two-entry valid/ready register stage. Both sides see registered signals.
// in_ready is low in reset and drops later only when both entries hold data.
`timescale 1ns/1ps
`default_nettype none

module handoff_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    // The skid entry catches the word that arrives while the output stalls
    logic     skid_valid;
    payload_t skid_data;
    logic     in_xfer;
    logic     load_main;
    logic     skid_valid_nxt;

    assign in_xfer = in_valid && in_ready;

    // The output entry may be refilled when it is empty or draining
    assign load_main = !out_valid || out_ready;

    always_comb
    begin
        skid_valid_nxt = skid_valid;
        if (load_main)
            skid_valid_nxt = 1'b0;
        else if (in_xfer)
            skid_valid_nxt = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end
        else
        begin
            skid_valid <= skid_valid_nxt;
            // Accept again as soon as the skid entry is free
            in_ready   <= !skid_valid_nxt;
            if (load_main)
                out_valid <= skid_valid || in_xfer;
        end
    end

    // Payload registers of the output entry and the skid entry
    always_ff @(posedge clk)
    begin
        if (load_main)
            out_data <= skid_valid ? skid_data : in_data;
        else if (in_xfer)
            skid_data <= in_data;
    end

endmodule

`default_nettype wire

//--- design/rsp_merge.sv
// Forwards sub-bursts to the port and merges in-order port responses.
// The port must answer every sub-burst once and in issue order.
// At most RSP_DEPTH sub-bursts wait for a response at any time.
`timescale 1ns/1ps
`default_nettype none

module rsp_merge import burst_cfg_pkg::*; import burst_types_pkg::*; #(
    parameter int RSP_DEPTH = RSP_DEPTH_DEF
) (
    input  logic               clk,
    input  logic               reset_n,
    sub_req_if.dst             sub,
    output logic               sub_valid,
    input  logic               sub_ready,
    output logic [ADDR_W-1:0]  sub_addr,
    output logic [S_LEN_W-1:0] sub_len,
    input  logic               prsp_valid,
    output logic               prsp_ready,
    input  logic               prsp_err,
    output logic               out_valid,
    output m_rsp_t             out_rsp,
    input  logic               out_ready
);

    localparam int PTR_W = (RSP_DEPTH > 1) ? $clog2(RSP_DEPTH) : 1;
    localparam int CNT_W = $clog2(RSP_DEPTH + 1);

    // Each entry holds {last, id} of one issued sub-burst
    logic [ID_W:0]      trk_mem [RSP_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               full;
    logic               push;
    logic               pop;
    logic               head_last;
    logic [ID_W-1:0]    head_id;
    logic               err_acc;

    assign full = (count == CNT_W'(RSP_DEPTH));

    // Request side is combinational and stalls while the tracker is full
    assign sub_valid = sub.valid && !full;
    assign sub.ready = sub_ready && !full;
    assign sub_addr  = sub.addr;
    assign sub_len   = sub.len;
    assign push      = sub.valid && sub.ready;

    assign {head_last, head_id} = trk_mem[rd_ptr];

    // A closing response needs room downstream, so the port waits on it
    assign prsp_ready = out_ready;
    assign pop        = prsp_valid && prsp_ready && (count != '0);

    assign out_valid   = prsp_valid && head_last && (count != '0);
    assign out_rsp.id  = head_id;
    assign out_rsp.err = err_acc || prsp_err;

    always_ff @(posedge clk)
    begin
        if (push)
            trk_mem[wr_ptr] <= {sub.last, sub.id};
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            err_acc <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            if (pop)
            begin
                rd_ptr  <= (rd_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
                // Error state restarts with each requester burst
                err_acc <= head_last ? 1'b0 : (err_acc || prsp_err);
            end
            if (push && !pop)
                count <= count + CNT_W'(1);
            else if (pop && !push)
                count <= count - CNT_W'(1);
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds and runs the testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing \
    --top-module burst_map_tb \
    -f burst_map.f \
    --Mdir obj_dir -o sim_burst_map
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_burst_map > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
fi
exit 1

//--- verification/burst_map_cases.txt
# name addr(hex) len(hex, beats-1) id(hex) err_sub(dec or none) subs(dec) err(dec)
# err_sub is the index of the sub-burst whose port response carries an error
full64_aligned 0000 3f 1 none 8 0
mis_start_err 0003 0c 2 1 3 1
short8 0010 07 3 none 1 0
short1 0021 00 4 none 1 0
cross_8 0006 09 5 0 2 1
full64_mis 0101 3f 6 7 11 1
odd_wrap 0ffd 04 7 none 3 0
short4_err 0024 03 8 0 1 1
top_aligned fff8 07 9 none 1 0
seven 0030 06 a none 3 0
mis_32 0005 1f b 4 7 1

//--- verification/burst_map_chk.sv
// Handshake assertions bound to the adapter top level.
// Payload checks hold only outside reset.
`timescale 1ns/1ps
`default_nettype none

module burst_map_chk import burst_cfg_pkg::*; (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               sub_valid,
    input  logic               sub_ready,
    input  logic [ADDR_W-1:0]  sub_addr,
    input  logic [S_LEN_W-1:0] sub_len,
    input  logic               rsp_valid,
    input  logic               rsp_ready,
    input  logic [ID_W-1:0]    rsp_id,
    input  logic               rsp_err
);

    // A stalled sub-burst keeps its valid and its payload
    sub_hold: assert property (@(posedge clk) disable iff (!reset_n)
        (sub_valid && !sub_ready) |=>
            (sub_valid && $stable(sub_addr) && $stable(sub_len)))
        else $error("sub payload changed while stalled");

    // A stalled requester response keeps its valid and its payload
    rsp_hold: assert property (@(posedge clk) disable iff (!reset_n)
        (rsp_valid && !rsp_ready) |=>
            (rsp_valid && $stable(rsp_id) && $stable(rsp_err)))
        else $error("rsp payload changed while stalled");

    // Both output channels are quiet while reset is applied
    reset_quiet: assert property (@(posedge clk)
        !reset_n |=> (!sub_valid && !rsp_valid))
        else $error("valid high during reset");

endmodule

bind burst_map_top burst_map_chk burst_map_chk_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .sub_valid (sub_valid),
    .sub_ready (sub_ready),
    .sub_addr  (sub_addr),
    .sub_len   (sub_len),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_id    (rsp_id),
    .rsp_err   (rsp_err)
);

`default_nettype wire

//--- verification/burst_map_tb.sv
// Testbench for the adapter with natural alignment and the default tracker depth.
// Cases come from verification/burst_map_cases.txt, run from the project root.
// The port model answers sub-bursts in order after random delays.
`timescale 1ns/1ps
`default_nettype none

module burst_map_tb import burst_cfg_pkg::*; ();

    localparam int DEPTH     = RSP_DEPTH_DEF;
    localparam int MAX_CASES = 32;
    localparam int HOLD_LEN  = 20;

    logic               clk;
    logic               reset_n;
    logic               req_valid;
    logic               req_ready;
    logic [ADDR_W-1:0]  req_addr;
    logic [M_LEN_W-1:0] req_len;
    logic [ID_W-1:0]    req_id;
    logic               sub_valid;
    logic               sub_ready;
    logic [ADDR_W-1:0]  sub_addr;
    logic [S_LEN_W-1:0] sub_len;
    logic               prsp_valid;
    logic               prsp_ready;
    logic               prsp_err;
    logic               rsp_valid;
    logic               rsp_ready;
    logic [ID_W-1:0]    rsp_id;
    logic               rsp_err;

    integer seed = 32'h9304_fca2;

    // Case table as read from the file
    string case_name [MAX_CASES];
    int    case_addr [MAX_CASES];
    int    case_len  [MAX_CASES];
    int    case_id   [MAX_CASES];
    int    case_esub [MAX_CASES];
    int    case_subs [MAX_CASES];
    int    case_err  [MAX_CASES];
    int    ref_subs  [MAX_CASES];
    int    seen_subs [MAX_CASES];
    int    n_cases   = 0;

    // Predicted sub-bursts in issue order, and error bits owed by the port
    int exp_addr_q [$];
    int exp_len_q  [$];
    int exp_case_q [$];
    int exp_idx_q  [$];
    bit pend_err_q [$];

    int issued       = 0;
    int answered     = 0;
    int rsp_count    = 0;
    int errors       = 0;
    int passed_cases = 0;
    int failed_cases = 0;
    int err_snap     = 0;
    int cycles       = 0;
    int limit        = 0;
    bit hold_rsp     = 1'b1;

    burst_map_top #(
        .NATURAL_ALIGNMENT(1'b1),
        .RSP_DEPTH(DEPTH)
    ) burst_map_top_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_addr   (req_addr),
        .req_len    (req_len),
        .req_id     (req_id),
        .sub_valid  (sub_valid),
        .sub_ready  (sub_ready),
        .sub_addr   (sub_addr),
        .sub_len    (sub_len),
        .prsp_valid (prsp_valid),
        .prsp_ready (prsp_ready),
        .prsp_err   (prsp_err),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_id     (rsp_id),
        .rsp_err    (rsp_err)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Largest power of two up to 8 that fits and divides the address
    function automatic int ref_beats(input int addr, input int rem);
        int p;
        p = 8;
        while ((p > rem) || ((addr % p) != 0))
            p = p / 2;
        return p;
    endfunction

    task automatic check(input string name, input int exp, input int act);
        if (exp != act)
        begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    // Queue every sub-burst that case i must produce
    task automatic predict(input int i);
        int addr;
        int rem;
        int b;
        int k;
        addr = case_addr[i];
        rem  = case_len[i] + 1;
        k    = 0;
        while (rem > 0)
        begin
            b = ref_beats(addr, rem);
            exp_addr_q.push_back(addr);
            exp_len_q.push_back(b - 1);
            exp_case_q.push_back(i);
            exp_idx_q.push_back(k);
            addr = (addr + b) & 32'hffff;
            rem  = rem - b;
            k++;
        end
        ref_subs[i] = k;
    endtask

    // Lines starting with # are comments and all numbers but the counts are hex
    function automatic bit load_cases();
        int    fd;
        int    n;
        int    a;
        int    l;
        int    d;
        int    s;
        int    e;
        string line;
        string nm;
        string tok;
        fd = $fopen("verification/burst_map_cases.txt", "r");
        if (fd == 0)
            return 1'b0;
        while (!$feof(fd) && (n_cases < MAX_CASES))
        begin
            line = "";
            n = $fgets(line, fd);
            if ((n > 1) && (line.getc(0) != "#"))
            begin
                n = $sscanf(line, "%s %h %h %h %s %d %d", nm, a, l, d, tok, s, e);
                if (n == 7)
                begin
                    case_name[n_cases] = nm;
                    case_addr[n_cases] = a;
                    case_len[n_cases]  = l;
                    case_id[n_cases]   = d;
                    case_esub[n_cases] = -1;
                    if (tok != "none")
                        n = $sscanf(tok, "%d", case_esub[n_cases]);
                    case_subs[n_cases] = s;
                    case_err[n_cases]  = e;
                    seen_subs[n_cases] = 0;
                    limit = limit + 20 * (l + 1);
                    n_cases++;
                end
            end
        end
        $fclose(fd);
        limit = limit + 200;
        return (n_cases > 0);
    endfunction

    task automatic run_cases();
        #1;
        check("sub_valid in reset", 0, int'(sub_valid));
        check("rsp_valid in reset", 0, int'(rsp_valid));
        check("req_ready in reset", 0, int'(req_ready));
        check("prsp_ready in reset", 0, int'(prsp_ready));
        reset_n = 1'b1;
        @(posedge clk);
        #1;
        check("req_ready after reset", 1, int'(req_ready));
        check("prsp_ready after reset", 1, int'(prsp_ready));
        for (int i = 0; i < n_cases; i++)
        begin
            req_valid = 1'b1;
            req_addr  = ADDR_W'(case_addr[i]);
            req_len   = M_LEN_W'(case_len[i]);
            req_id    = ID_W'(case_id[i]);
            @(posedge clk);
            while (!req_ready)
                @(posedge clk);
            predict(i);
            #1;
        end
        req_valid = 1'b0;
        while (rsp_count < n_cases)
            @(posedge clk);
        repeat (4) @(posedge clk);
        check("leftover sub-bursts", 0, exp_addr_q.size());
        check("unanswered sub-bursts", 0, pend_err_q.size());
    endtask

    initial
    begin
        reset_n    = 1'b0;
        req_valid  = 1'b0;
        req_addr   = '0;
        req_len    = '0;
        req_id     = '0;
        sub_ready  = 1'b0;
        prsp_valid = 1'b0;
        prsp_err   = 1'b0;
        rsp_ready  = 1'b0;
        if (!load_cases())
        begin
            $display("Could not read any case from the case file");
            $display("SIMULATION FAILED");
            $finish;
        end
        else
        begin
            repeat (2) @(posedge clk);
            run_cases();
            $display("Cases passed %0d, failed %0d, errors %0d",
                     passed_cases, failed_cases, errors);
            if ((errors == 0) && (failed_cases == 0))
                $display("SIMULATION PASSED");
            else
                $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Port and requester models sample at the edge and drive 1 ns later
    initial
    begin
        int  ci;
        int  wait_cnt;
        int  hold_cycles;
        int  stretch;
        bit  prsp_taken;
        wait_cnt    = 0;
        hold_cycles = 0;
        stretch     = 0;
        forever
        begin
            @(posedge clk);
            prsp_taken = 1'b0;
            if (reset_n)
            begin
                if (sub_valid && sub_ready)
                begin
                    check("tracker limit", 1, int'((issued - answered) < DEPTH));
                    if (exp_addr_q.size() == 0)
                    begin
                        $display("A sub-burst was issued that no request asked for");
                        errors++;
                    end
                    else
                    begin
                        ci = exp_case_q.pop_front();
                        check({case_name[ci], " sub addr"}, exp_addr_q.pop_front(),
                              int'(sub_addr));
                        check({case_name[ci], " sub len"}, exp_len_q.pop_front(),
                              int'(sub_len));
                        pend_err_q.push_back(exp_idx_q.pop_front() == case_esub[ci]);
                        seen_subs[ci]++;
                    end
                    issued++;
                end
                if (prsp_valid && prsp_ready)
                begin
                    void'(pend_err_q.pop_front());
                    answered++;
                    prsp_taken = 1'b1;
                end
                if (rsp_valid && rsp_ready)
                begin
                    if (rsp_count >= n_cases)
                    begin
                        $display("A requester response arrived with no burst pending");
                        errors++;
                    end
                    else
                    begin
                        ci = rsp_count;
                        check({case_name[ci], " id"}, case_id[ci], int'(rsp_id));
                        check({case_name[ci], " err"}, case_err[ci], int'(rsp_err));
                        check({case_name[ci], " count"}, case_subs[ci], seen_subs[ci]);
                        check({case_name[ci], " ref count"}, ref_subs[ci], seen_subs[ci]);
                        if (errors == err_snap)
                        begin
                            $display("Case %s: PASS", case_name[ci]);
                            passed_cases++;
                        end
                        else
                        begin
                            $display("Case %s: FAIL", case_name[ci]);
                            failed_cases++;
                        end
                        err_snap = errors;
                    end
                    rsp_count++;
                end
            end
            #1;
            sub_ready = (($random(seed) & 3) != 0);
            // Responses are withheld until the tracker has been full for a while
            if (hold_rsp && ((issued - answered) == DEPTH))
            begin
                hold_cycles++;
                if (hold_cycles >= HOLD_LEN)
                    hold_rsp = 1'b0;
            end
            if (prsp_taken)
            begin
                prsp_valid = 1'b0;
                wait_cnt   = $random(seed) & 3;
            end
            if (!prsp_valid && !hold_rsp && (pend_err_q.size() > 0))
            begin
                if (wait_cnt == 0)
                begin
                    prsp_valid = 1'b1;
                    prsp_err   = pend_err_q[0];
                end
                else
                    wait_cnt--;
            end
            // Requester back-pressure with occasional long low stretches
            if (stretch > 0)
            begin
                stretch--;
                rsp_ready = 1'b0;
            end
            else if (($random(seed) & 15) == 0)
            begin
                stretch   = 10;
                rsp_ready = 1'b0;
            end
            else
                rsp_ready = (($random(seed) & 7) != 0);
        end
    end

    initial
    begin
        wait (limit > 0);
        while (cycles < limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d of %0d responses received",
                 cycles, rsp_count, n_cases);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire
